//--- source/core_types_pkg.sv
package core_types_pkg;

    // --------------------------------------------------------------------
    // basic fetch and decode types

    typedef logic [31:0] pc_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [3:0] {
        OP_BRANCH  = 4'h0,
        OP_JAL     = 4'h1,
        OP_JALR    = 4'h2,
        OP_LOAD    = 4'h3,
        OP_STORE   = 4'h4,
        OP_ALU_IMM = 4'h5,
        OP_ALU_REG = 4'h6,
        OP_LUI     = 4'h7,
        OP_AUIPC   = 4'h8,
        OP_OTHER   = 4'h9
    } op_class_t;

    // major opcodes in instr[6:0]
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    // one instruction queue entry, 69 bits
    typedef struct packed {
        pc_t       pc;
        instr_t    instr;
        logic      is_compressed;
        op_class_t op_class;
    } istream_entry_t;

endpackage

//--- source/queue_cfg_pkg.sv
package queue_cfg_pkg;

    // queue depth, deliberately not a power of two
    localparam int IQ_ENTRIES = 6;

    localparam int IQ_PTR_W = $clog2(IQ_ENTRIES);

    // occupancy needs to hold 0 through IQ_ENTRIES
    localparam int IQ_CNT_W = IQ_PTR_W + 1;

endpackage

//--- source/distram_1rport_1wport.sv
`timescale 1ns/10ps

module distram_1rport_1wport
    import core_types_pkg::*;
    import queue_cfg_pkg::*;
(
    input  logic                CLK,

    // async read port
    input  logic [IQ_PTR_W-1:0] rindex,
    output istream_entry_t      rdata,

    // sync write port
    input  logic                wen,
    input  logic [IQ_PTR_W-1:0] windex,
    input  istream_entry_t      wdata
);

    istream_entry_t mem [IQ_ENTRIES];

    always_ff @(posedge CLK) begin
        if (wen) begin
            mem[windex] <= wdata;
        end
    end

    assign rdata = mem[rindex];

endmodule

//--- source/fetch_predecode.sv
`timescale 1ns/10ps

module fetch_predecode
    import core_types_pkg::*;
(
    input  logic           CLK,
    input  logic           nRST,

    // fetch strobe
    input  logic           fetch_valid,
    input  pc_t            fetch_pc,
    input  instr_t         fetch_instr,

    // to buffer
    output logic           enq_valid,
    output istream_entry_t enq_data
);

    logic      is_compressed;
    op_class_t op_class;

    // --------------------------------------------------------------------
    // classify by opcode

    assign is_compressed = (fetch_instr[1:0] != 2'b11);

    always_comb begin
        op_class = OP_OTHER;
        if (!is_compressed) begin
            case (fetch_instr[6:0])
                OPC_BRANCH: op_class = OP_BRANCH;
                OPC_JAL:    op_class = OP_JAL;
                OPC_JALR:   op_class = OP_JALR;
                OPC_LOAD:   op_class = OP_LOAD;
                OPC_STORE:  op_class = OP_STORE;
                OPC_OP_IMM: op_class = OP_ALU_IMM;
                OPC_OP:     op_class = OP_ALU_REG;
                OPC_LUI:    op_class = OP_LUI;
                OPC_AUIPC:  op_class = OP_AUIPC;
                default:    op_class = OP_OTHER;
            endcase
        end
    end

    // --------------------------------------------------------------------
    // predecode register

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            enq_valid <= 1'b0;
        end
        else begin
            enq_valid <= fetch_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (fetch_valid) begin
            enq_data.pc            <= fetch_pc;
            enq_data.instr         <= fetch_instr;
            enq_data.is_compressed <= is_compressed;
            enq_data.op_class      <= op_class;
        end
    end

endmodule

//--- source/cb.sv
`timescale 1ns/10ps

module cb
    import core_types_pkg::*;
    import queue_cfg_pkg::*;
(
    input  logic           CLK,
    input  logic           nRST,

    // enq
    input  logic           enq_valid,
    input  istream_entry_t enq_data,
    output logic           enq_ready,

    // deq
    output logic           deq_valid,
    output istream_entry_t deq_data,
    input  logic           deq_ready
);

    logic [IQ_PTR_W-1:0] enq_ptr, enq_ptr_plus_1;
    logic [IQ_PTR_W-1:0] deq_ptr, deq_ptr_plus_1;
    logic [IQ_CNT_W-1:0] count;
    logic                deq_fire;

    assign deq_fire = deq_valid & deq_ready;

    // --------------------------------------------------------------------
    // pointer increment

    generate
        if ((IQ_ENTRIES & (IQ_ENTRIES - 1)) == 0) begin : g_pow2
            // natural wrap
            assign enq_ptr_plus_1 = enq_ptr + IQ_PTR_W'(1);
            assign deq_ptr_plus_1 = deq_ptr + IQ_PTR_W'(1);
        end
        else begin : g_wrap
            always_comb begin
                if (enq_ptr == IQ_PTR_W'(IQ_ENTRIES - 1)) begin
                    enq_ptr_plus_1 = '0;
                end
                else begin
                    enq_ptr_plus_1 = enq_ptr + IQ_PTR_W'(1);
                end
                if (deq_ptr == IQ_PTR_W'(IQ_ENTRIES - 1)) begin
                    deq_ptr_plus_1 = '0;
                end
                else begin
                    deq_ptr_plus_1 = deq_ptr + IQ_PTR_W'(1);
                end
            end
        end
    endgenerate

    // --------------------------------------------------------------------
    // pointers, occupancy, deq_valid

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            enq_ptr   <= '0;
            deq_ptr   <= '0;
            count     <= '0;
            deq_valid <= 1'b0;
        end
        else begin
            if (enq_valid) begin
                enq_ptr <= enq_ptr_plus_1;
            end
            if (deq_fire) begin
                deq_ptr <= deq_ptr_plus_1;
            end
            if (enq_valid & ~deq_fire) begin
                count     <= count + IQ_CNT_W'(1);
                deq_valid <= 1'b1;
            end
            if (deq_fire & ~enq_valid) begin
                count     <= count - IQ_CNT_W'(1);
                deq_valid <= (deq_ptr_plus_1 != enq_ptr);
            end
        end
    end

    // leave room for the entry still sitting in predecode
    assign enq_ready = (count + IQ_CNT_W'(enq_valid)) < IQ_CNT_W'(IQ_ENTRIES);

    distram_1rport_1wport distram_buffer (
        .CLK    (CLK),
        .rindex (deq_ptr),
        .rdata  (deq_data),
        .wen    (enq_valid),
        .windex (enq_ptr),
        .wdata  (enq_data)
    );

endmodule

//--- source/decode_unpack.sv
`timescale 1ns/10ps

module decode_unpack
    import core_types_pkg::*;
(
    input  logic           CLK,
    input  logic           nRST,

    // from buffer
    input  logic           deq_valid,
    input  istream_entry_t deq_data,
    output logic           deq_ready,

    // to decode
    input  logic           decode_ready,
    output logic           decode_valid,
    output pc_t            decode_pc,
    output op_class_t      decode_class,
    output reg_idx_t       decode_rd,
    output reg_idx_t       decode_rs1,
    output reg_idx_t       decode_rs2,
    output logic [31:0]    decode_imm,
    output pc_t            decode_next_pc
);

    instr_t      instr;
    logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    reg_idx_t    dec_rd, dec_rs1, dec_rs2;
    logic [31:0] dec_imm;
    pc_t         dec_next_pc;
    logic        deq_fire;

    // --------------------------------------------------------------------
    // immediates, all sign-extended

    assign instr = deq_data.instr;
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // fields the format lacks stay zero
    always_comb begin
        dec_rd  = '0;
        dec_rs1 = '0;
        dec_rs2 = '0;
        dec_imm = '0;
        case (deq_data.op_class)
            OP_BRANCH: begin
                dec_rs1 = instr[19:15];
                dec_rs2 = instr[24:20];
                dec_imm = imm_b;
            end
            OP_STORE: begin
                dec_rs1 = instr[19:15];
                dec_rs2 = instr[24:20];
                dec_imm = imm_s;
            end
            OP_JALR, OP_LOAD, OP_ALU_IMM: begin
                dec_rd  = instr[11:7];
                dec_rs1 = instr[19:15];
                dec_imm = imm_i;
            end
            OP_ALU_REG: begin
                dec_rd  = instr[11:7];
                dec_rs1 = instr[19:15];
                dec_rs2 = instr[24:20];
            end
            OP_JAL: begin
                dec_rd  = instr[11:7];
                dec_imm = imm_j;
            end
            OP_LUI, OP_AUIPC: begin
                dec_rd  = instr[11:7];
                dec_imm = imm_u;
            end
            default: begin
                // compressed and unknown pass through empty
                dec_rd = '0;
            end
        endcase
    end

    assign dec_next_pc = deq_data.pc + (deq_data.is_compressed ? 32'd2 : 32'd4);

    // --------------------------------------------------------------------
    // output register

    assign deq_ready = ~decode_valid | decode_ready;
    assign deq_fire  = deq_valid & deq_ready;

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            decode_valid <= 1'b0;
        end
        else if (deq_fire) begin
            decode_valid <= 1'b1;
        end
        else if (decode_ready) begin
            decode_valid <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (deq_fire) begin
            decode_pc      <= deq_data.pc;
            decode_class   <= deq_data.op_class;
            decode_rd      <= dec_rd;
            decode_rs1     <= dec_rs1;
            decode_rs2     <= dec_rs2;
            decode_imm     <= dec_imm;
            decode_next_pc <= dec_next_pc;
        end
    end

endmodule

//--- source/fetch_queue_top.sv
`timescale 1ns/10ps

module fetch_queue_top
    import core_types_pkg::*;
(
    input  logic        CLK,
    input  logic        nRST,

    // fetch side
    input  logic        fetch_valid,
    input  pc_t         fetch_pc,
    input  instr_t      fetch_instr,
    output logic        fetch_ready,

    // decode side
    input  logic        decode_ready,
    output logic        decode_valid,
    output pc_t         decode_pc,
    output op_class_t   decode_class,
    output reg_idx_t    decode_rd,
    output reg_idx_t    decode_rs1,
    output reg_idx_t    decode_rs2,
    output logic [31:0] decode_imm,
    output pc_t         decode_next_pc
);

    logic           enq_valid;
    istream_entry_t enq_data;
    logic           deq_valid;
    istream_entry_t deq_data;
    logic           deq_ready;

    fetch_predecode predecode (
        .CLK         (CLK),
        .nRST        (nRST),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_instr (fetch_instr),
        .enq_valid   (enq_valid),
        .enq_data    (enq_data)
    );

    cb buffer (
        .CLK       (CLK),
        .nRST      (nRST),
        .enq_valid (enq_valid),
        .enq_data  (enq_data),
        .enq_ready (fetch_ready),
        .deq_valid (deq_valid),
        .deq_data  (deq_data),
        .deq_ready (deq_ready)
    );

    decode_unpack unpack (
        .CLK            (CLK),
        .nRST           (nRST),
        .deq_valid      (deq_valid),
        .deq_data       (deq_data),
        .deq_ready      (deq_ready),
        .decode_ready   (decode_ready),
        .decode_valid   (decode_valid),
        .decode_pc      (decode_pc),
        .decode_class   (decode_class),
        .decode_rd      (decode_rd),
        .decode_rs1     (decode_rs1),
        .decode_rs2     (decode_rs2),
        .decode_imm     (decode_imm),
        .decode_next_pc (decode_next_pc)
    );

endmodule

//--- sim/fetch_queue_asserts.sv
`timescale 1ns/10ps

module fetch_queue_asserts
    import core_types_pkg::*;
    import queue_cfg_pkg::*;
(
    input  logic                CLK,
    input  logic                nRST,
    input  logic                enq_valid,
    input  logic                enq_ready,
    input  logic [IQ_CNT_W-1:0] count,
    input  logic                deq_valid,
    input  logic                deq_ready,
    input  logic                decode_valid,
    input  logic                decode_ready,
    input  pc_t                 decode_pc,
    input  op_class_t           decode_class,
    input  logic [31:0]         decode_imm
);

    // predecode must never push into a full buffer
    a_no_enq_when_full: assert property (@(posedge CLK) disable iff (!nRST)
        enq_valid |-> count < IQ_CNT_W'(IQ_ENTRIES))
        else $error("enqueue while buffer full");

    a_deq_valid_hold: assert property (@(posedge CLK) disable iff (!nRST)
        deq_valid && !deq_ready |=> deq_valid)
        else $error("deq_valid dropped without a dequeue");

    // stalled decode output holds
    a_decode_stable: assert property (@(posedge CLK) disable iff (!nRST)
        decode_valid && !decode_ready |=> decode_valid && $stable(decode_pc)
            && $stable(decode_class) && $stable(decode_imm))
        else $error("decode output changed while stalled");

    a_ready_after_reset: assert property (@(posedge CLK)
        $rose(nRST) |=> enq_ready)
        else $error("fetch_ready low after reset release");

endmodule

bind cb fetch_queue_asserts buffer_checks (
    .CLK          (CLK),
    .nRST         (nRST),
    .enq_valid    (enq_valid),
    .enq_ready    (enq_ready),
    .count        (count),
    .deq_valid    (deq_valid),
    .deq_ready    (deq_ready),
    .decode_valid (1'b0),
    .decode_ready (1'b1),
    .decode_pc    ('0),
    .decode_class (OP_OTHER),
    .decode_imm   ('0)
);

bind decode_unpack fetch_queue_asserts unpack_checks (
    .CLK          (CLK),
    .nRST         (nRST),
    .enq_valid    (1'b0),
    .enq_ready    (1'b1),
    .count        ('0),
    .deq_valid    (deq_valid),
    .deq_ready    (deq_ready),
    .decode_valid (decode_valid),
    .decode_ready (decode_ready),
    .decode_pc    (decode_pc),
    .decode_class (decode_class),
    .decode_imm   (decode_imm)
);

//--- sim/fetch_queue_tb.sv
`timescale 1ns/10ps

module fetch_queue_tb
    import core_types_pkg::*;
();

    localparam int NUM_CASES      = 20;
    localparam int WORDS_PER_CASE = 8;
    localparam int CYCLE_LIMIT    = 40 * NUM_CASES + 100;
    localparam int STALL_START    = 8;
    localparam int STALL_CYCLES   = 20;

    logic        CLK;
    logic        nRST;
    logic        fetch_valid;
    pc_t         fetch_pc;
    instr_t      fetch_instr;
    logic        fetch_ready;
    logic        decode_ready;
    logic        decode_valid;
    pc_t         decode_pc;
    op_class_t   decode_class;
    reg_idx_t    decode_rd;
    reg_idx_t    decode_rs1;
    reg_idx_t    decode_rs2;
    logic [31:0] decode_imm;
    pc_t         decode_next_pc;

    logic [31:0] cases_mem [NUM_CASES*WORDS_PER_CASE];
    logic [31:0] lfsr_state;
    int          send_idx;
    int          check_idx;
    int          cycles;
    int          stall_left;
    bit          stall_done;
    bit          seen_full;

    fetch_queue_top dut (
        .CLK            (CLK),
        .nRST           (nRST),
        .fetch_valid    (fetch_valid),
        .fetch_pc       (fetch_pc),
        .fetch_instr    (fetch_instr),
        .fetch_ready    (fetch_ready),
        .decode_ready   (decode_ready),
        .decode_valid   (decode_valid),
        .decode_pc      (decode_pc),
        .decode_class   (decode_class),
        .decode_rd      (decode_rd),
        .decode_rs1     (decode_rs1),
        .decode_rs2     (decode_rs2),
        .decode_imm     (decode_imm),
        .decode_next_pc (decode_next_pc)
    );

    always #10 CLK = ~CLK;

    // ----------------------------------------------------------------------
    // random bits, taps 32 22 2 1

    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function logic random_bit();
        lfsr_state = next_lfsr(lfsr_state);
        return lfsr_state[0];
    endfunction

    // ----------------------------------------------------------------------
    // failure reporting and compares

    task automatic fail_with_message(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("[ERROR] case %0d %s expected 0x%h actual 0x%h", check_idx, name, exp, act);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic compare_pc(input string name, input pc_t exp, input pc_t act);
        if (act !== exp) begin
            report_mismatch(name, exp, act);
        end
    endtask

    task automatic compare_class(input string name, input op_class_t exp, input op_class_t act);
        if (act !== exp) begin
            report_mismatch(name, 32'(exp), 32'(act));
        end
    endtask

    task automatic compare_reg(input string name, input reg_idx_t exp, input reg_idx_t act);
        if (act !== exp) begin
            report_mismatch(name, 32'(exp), 32'(act));
        end
    endtask

    task automatic compare_imm(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            report_mismatch(name, exp, act);
        end
    endtask

    task automatic check_outputs(input int idx);
        int base;
        base = idx * WORDS_PER_CASE;
        compare_pc("decode_pc", cases_mem[base], decode_pc);
        compare_class("decode_class", op_class_t'(cases_mem[base+2][3:0]), decode_class);
        compare_reg("decode_rd", cases_mem[base+3][4:0], decode_rd);
        compare_reg("decode_rs1", cases_mem[base+4][4:0], decode_rs1);
        compare_reg("decode_rs2", cases_mem[base+5][4:0], decode_rs2);
        compare_imm("decode_imm", cases_mem[base+6], decode_imm);
        compare_pc("decode_next_pc", cases_mem[base+7], decode_next_pc);
    endtask

    // ----------------------------------------------------------------------
    // stimulus, called on the falling edge

    task automatic drive_case(input int idx);
        fetch_valid = 1'b1;
        fetch_pc    = cases_mem[idx*WORDS_PER_CASE];
        fetch_instr = cases_mem[idx*WORDS_PER_CASE+1];
    endtask

    task automatic step_decode_ready();
        logic b0;
        logic b1;
        if (!stall_done && send_idx >= STALL_START) begin
            stall_left = STALL_CYCLES;
            stall_done = 1'b1;
        end
        if (stall_left > 0) begin
            decode_ready = 1'b0;
            stall_left--;
            if (!fetch_ready) begin
                seen_full = 1'b1;
            end
        end
        else begin
            // low one time in four
            b0 = random_bit();
            b1 = random_bit();
            decode_ready = b0 | b1;
        end
    endtask

    task automatic step_fetch();
        logic idle;
        fetch_valid = 1'b0;
        if (send_idx < NUM_CASES && fetch_ready) begin
            idle = (stall_left == 0) ? random_bit() : 1'b0;
            if (!idle) begin
                drive_case(send_idx);
                send_idx++;
            end
        end
    endtask

    // ----------------------------------------------------------------------
    // timeout

    always @(posedge CLK) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            fail_with_message("timeout waiting for all instructions to reach decode");
        end
    end

    initial begin
        CLK          = 1'b0;
        nRST         = 1'b0;
        fetch_valid  = 1'b0;
        fetch_pc     = '0;
        fetch_instr  = '0;
        decode_ready = 1'b1;
        lfsr_state   = 32'h38bb_8149;
        send_idx     = 0;
        check_idx    = 0;
        cycles       = 0;
        stall_left   = 0;
        stall_done   = 1'b0;
        seen_full    = 1'b0;
        $readmemh("sim/fetch_cases.txt", cases_mem);

        repeat (4) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
        @(negedge CLK);
        if (decode_valid !== 1'b0 || fetch_ready !== 1'b1) begin
            fail_with_message("decode_valid or fetch_ready wrong after reset");
        end

        // first instruction with decode never stalled
        drive_case(0);
        send_idx = 1;
        @(negedge CLK);
        fetch_valid = 1'b0;
        if (decode_valid !== 1'b0) begin
            fail_with_message("first instruction reached decode one cycle after its strobe");
        end
        @(negedge CLK);
        if (decode_valid !== 1'b0) begin
            fail_with_message("first instruction reached decode two cycles after its strobe");
        end
        @(negedge CLK);
        if (decode_valid !== 1'b1) begin
            fail_with_message("first instruction missing at decode three cycles after its strobe");
        end

        while (check_idx < NUM_CASES) begin
            step_decode_ready();
            // handshake at the coming rising edge
            if (decode_valid && decode_ready) begin
                check_outputs(check_idx);
                check_idx++;
            end
            step_fetch();
            @(negedge CLK);
        end

        if (!seen_full) begin
            fail_with_message("fetch_ready never dropped while decode was stalled");
        end
        else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

//--- project.f
source/core_types_pkg.sv
source/queue_cfg_pkg.sv
source/distram_1rport_1wport.sv
source/fetch_predecode.sv
source/cb.sv
source/decode_unpack.sv
source/fetch_queue_top.sv
sim/fetch_queue_asserts.sv
sim/fetch_queue_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the fetch queue testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module fetch_queue_tb \
    -f project.f \
    -o Vfetch_queue_tb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/Vfetch_queue_tb
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0

//--- sim/fetch_cases.txt
// pc       instr    class rd rs1 rs2 imm      next_pc
// class: 0 branch 1 jal 2 jalr 3 load 4 store 5 alu_imm 6 alu_reg 7 lui 8 auipc 9 other
00001000 00500093 5 01 00 00 00000005 00001004
00001004 fff08113 5 02 01 00 ffffffff 00001008
00001008 002081b3 6 03 01 02 00000000 0000100c
0000100c 00812283 3 05 02 00 00000008 00001010
00001010 fe512e23 4 00 02 05 fffffffc 00001014
00001014 fe208ce3 0 00 01 02 fffffff8 00001018
00001018 ff1ff0ef 1 01 00 00 fffffff0 0000101c
0000101c 00008067 2 00 01 00 00000000 00001020
00001020 12345537 7 0a 00 00 12345000 00001024
00001024 fffff597 8 0b 00 00 fffff000 00001028
00001028 00004501 9 00 00 00 00000000 0000102a
0000102a 0000000f 9 00 00 00 00000000 0000102e
0000102e 00419863 0 00 03 04 00000010 00001032
00001032 0010006f 1 00 00 00 00000800 00001036
00001036 406283b3 6 07 05 06 00000000 0000103a
0000103a 80048403 3 08 09 00 fffff800 0000103e
0000103e 7e848fa3 4 00 09 08 000007ff 00001042
00001042 001f8f93 5 1f 1f 00 00000001 00001046
00001046 00000073 9 00 00 00 00000000 0000104a
0000104a 00008082 9 00 00 00 00000000 0000104c
